// File: logic/instr_pkg.sv
//================================================
// Statistics block shared definitions
// Register map, fixed readback words and the
// data widths used across the counter banks
//================================================

package instr_pkg;

    //================================================
    // Data types
    //================================================

    typedef logic [31:0] reg_data_t;
    typedef logic [11:0] reg_offset_t;
    typedef logic [31:0] count_t;
    typedef logic [63:0] byte_count_t;

    // Receive, transmit and sector FIFOs share one depth
    typedef logic [9:0]  fifo_level_t;
    typedef logic [12:0] flux_level_t;
    typedef logic [15:0] dma_len_t;

    //================================================
    // Fixed words
    //================================================

    localparam reg_data_t version_word    = 32'h0001_0000;
    localparam reg_data_t bad_offset_word = 32'hDEAD_BEEF;

    // One 32-bit word per USB handshake
    localparam int unsigned usb_word_bytes = 4;

    //================================================
    // Register offsets
    //================================================

    localparam reg_offset_t reg_version         = 12'h000;
    localparam reg_offset_t reg_control         = 12'h004;

    localparam reg_offset_t reg_usb_rx_bytes_lo = 12'h040;
    localparam reg_offset_t reg_usb_rx_bytes_hi = 12'h044;
    localparam reg_offset_t reg_usb_tx_bytes_lo = 12'h048;
    localparam reg_offset_t reg_usb_tx_bytes_hi = 12'h04C;
    localparam reg_offset_t reg_usb_rx_packets  = 12'h050;
    localparam reg_offset_t reg_usb_tx_packets  = 12'h054;
    localparam reg_offset_t reg_usb_errors      = 12'h058;

    localparam reg_offset_t reg_dma_bytes_lo    = 12'h080;
    localparam reg_offset_t reg_dma_bytes_hi    = 12'h084;
    localparam reg_offset_t reg_dma_transfers   = 12'h088;
    localparam reg_offset_t reg_dma_errors      = 12'h08C;

    localparam reg_offset_t reg_fifo_rx_hwm     = 12'h0C0;
    localparam reg_offset_t reg_fifo_tx_hwm     = 12'h0C4;
    localparam reg_offset_t reg_fifo_flux_hwm   = 12'h0C8;
    localparam reg_offset_t reg_fifo_sector_hwm = 12'h0CC;
    localparam reg_offset_t reg_fifo_overflows  = 12'h0D0;

    // Disk side errors with the total computed at readback
    localparam reg_offset_t reg_err_fdd         = 12'h1C0;
    localparam reg_offset_t reg_err_hdd         = 12'h1C4;
    localparam reg_offset_t reg_err_crc         = 12'h1C8;
    localparam reg_offset_t reg_err_timeout     = 12'h1CC;
    localparam reg_offset_t reg_err_total       = 12'h1D0;

endpackage

// File: logic/bus_decode.sv
//================================================
// Register bus front end
// Acknowledges every request after one cycle and
// turns control writes into a clear pulse
//================================================

module bus_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  instr_pkg::reg_data_t    reg_addr,
    input  instr_pkg::reg_data_t    reg_wdata,
    input  logic                    reg_we,
    input  logic                    reg_re,
    output logic                    reg_ready,
    output logic                    rd_en,
    output instr_pkg::reg_offset_t  rd_offset,
    output logic                    counters_clear
);

    instr_pkg::reg_offset_t offset;
    logic                   request;
    logic                   clear_hit;

    // Only the low address bits select a register
    assign offset    = reg_addr[11:0];
    assign request   = reg_we || reg_re;
    assign clear_hit = reg_we && (offset == instr_pkg::reg_control) && reg_wdata[0];

    // Readback mux samples on the request edge itself
    assign rd_en     = reg_re;
    assign rd_offset = offset;

    //================================================
    // Handshake and control
    //================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_ready      <= 1'b0;
            counters_clear <= 1'b0;
        end else begin
            // One ready per request and no back-pressure
            reg_ready      <= request;
            counters_clear <= clear_hit;
        end
    end

    // Ready only ever answers a request from the cycle before
    a_ready_follows_request : assert property (
        @(posedge clk) disable iff (!rst_n)
        reg_ready |-> $past(request)
    );

endmodule

// File: logic/traffic_counters.sv
//================================================
// USB and DMA transfer statistics
// Handshake, byte and error counts for both paths
//================================================

module traffic_counters (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    counters_clear,

    input  logic                    usb_rx_valid,
    input  logic                    usb_rx_ready,
    input  logic                    usb_tx_valid,
    input  logic                    usb_tx_ready,
    input  logic                    usb_error,
    input  logic                    dma_done,
    input  logic                    dma_error,
    input  instr_pkg::dma_len_t     dma_length,

    output instr_pkg::byte_count_t  usb_rx_bytes,
    output instr_pkg::byte_count_t  usb_tx_bytes,
    output instr_pkg::byte_count_t  dma_bytes,
    output instr_pkg::count_t       usb_rx_packets,
    output instr_pkg::count_t       usb_tx_packets,
    output instr_pkg::count_t       usb_errors,
    output instr_pkg::count_t       dma_transfers,
    output instr_pkg::count_t       dma_errors
);

    localparam instr_pkg::byte_count_t word_bytes =
        instr_pkg::byte_count_t'(instr_pkg::usb_word_bytes);

    logic usb_rx_hs;
    logic usb_tx_hs;

    assign usb_rx_hs = usb_rx_valid && usb_rx_ready;
    assign usb_tx_hs = usb_tx_valid && usb_tx_ready;

    //================================================
    // USB statistics
    //================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            usb_rx_bytes   <= '0;
            usb_tx_bytes   <= '0;
            usb_rx_packets <= '0;
            usb_tx_packets <= '0;
            usb_errors     <= '0;
        end else if (counters_clear) begin
            usb_rx_bytes   <= '0;
            usb_tx_bytes   <= '0;
            usb_rx_packets <= '0;
            usb_tx_packets <= '0;
            usb_errors     <= '0;
        end else begin
            if (usb_rx_hs) begin
                usb_rx_bytes   <= usb_rx_bytes + word_bytes;
                usb_rx_packets <= usb_rx_packets + 1'b1;
            end
            if (usb_tx_hs) begin
                usb_tx_bytes   <= usb_tx_bytes + word_bytes;
                usb_tx_packets <= usb_tx_packets + 1'b1;
            end
            if (usb_error)
                usb_errors <= usb_errors + 1'b1;
        end
    end

    //================================================
    // DMA statistics
    //================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dma_bytes     <= '0;
            dma_transfers <= '0;
            dma_errors    <= '0;
        end else if (counters_clear) begin
            dma_bytes     <= '0;
            dma_transfers <= '0;
            dma_errors    <= '0;
        end else begin
            // Length is only meaningful with done
            if (dma_done) begin
                dma_bytes     <= dma_bytes + {48'd0, dma_length};
                dma_transfers <= dma_transfers + 1'b1;
            end
            if (dma_error)
                dma_errors <= dma_errors + 1'b1;
        end
    end

    a_packets_monotonic : assert property (
        @(posedge clk) disable iff (!rst_n)
        !counters_clear |=> (usb_rx_packets >= $past(usb_rx_packets)) &&
                            (usb_tx_packets >= $past(usb_tx_packets))
    );

endmodule

// File: logic/fault_counters.sv
//================================================
// FIFO and disk fault statistics
// High-water marks, FIFO flag count and per-source
// disk error counters
//================================================

module fault_counters (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    counters_clear,

    input  instr_pkg::fifo_level_t  rx_fifo_level,
    input  instr_pkg::fifo_level_t  tx_fifo_level,
    input  instr_pkg::fifo_level_t  sector_fifo_level,
    input  instr_pkg::flux_level_t  flux_fifo_level,
    input  logic                    rx_fifo_overflow,
    input  logic                    tx_fifo_underrun,
    input  logic                    flux_fifo_overflow,
    input  logic                    fdd_error,
    input  logic                    hdd_error,
    input  logic                    crc_error,
    input  logic                    timeout_error,

    output instr_pkg::fifo_level_t  rx_hwm,
    output instr_pkg::fifo_level_t  tx_hwm,
    output instr_pkg::fifo_level_t  sector_hwm,
    output instr_pkg::flux_level_t  flux_hwm,
    output instr_pkg::count_t       fifo_overflows,
    output instr_pkg::count_t       err_fdd,
    output instr_pkg::count_t       err_hdd,
    output instr_pkg::count_t       err_crc,
    output instr_pkg::count_t       err_timeout
);

    logic fifo_fault;

    // Several flags in one cycle still count once
    assign fifo_fault = rx_fifo_overflow || tx_fifo_underrun || flux_fifo_overflow;

    //================================================
    // FIFO monitoring
    //================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_hwm         <= '0;
            tx_hwm         <= '0;
            sector_hwm     <= '0;
            flux_hwm       <= '0;
            fifo_overflows <= '0;
        end else if (counters_clear) begin
            rx_hwm         <= '0;
            tx_hwm         <= '0;
            sector_hwm     <= '0;
            flux_hwm       <= '0;
            fifo_overflows <= '0;
        end else begin
            if (rx_fifo_level > rx_hwm)
                rx_hwm <= rx_fifo_level;
            if (tx_fifo_level > tx_hwm)
                tx_hwm <= tx_fifo_level;
            if (sector_fifo_level > sector_hwm)
                sector_hwm <= sector_fifo_level;
            if (flux_fifo_level > flux_hwm)
                flux_hwm <= flux_fifo_level;
            if (fifo_fault)
                fifo_overflows <= fifo_overflows + 1'b1;
        end
    end

    //================================================
    // Disk errors
    //================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_fdd     <= '0;
            err_hdd     <= '0;
            err_crc     <= '0;
            err_timeout <= '0;
        end else if (counters_clear) begin
            err_fdd     <= '0;
            err_hdd     <= '0;
            err_crc     <= '0;
            err_timeout <= '0;
        end else begin
            err_fdd     <= err_fdd + count_inc(fdd_error);
            err_hdd     <= err_hdd + count_inc(hdd_error);
            err_crc     <= err_crc + count_inc(crc_error);
            err_timeout <= err_timeout + count_inc(timeout_error);
        end
    end

    function automatic instr_pkg::count_t count_inc(input logic ev);
        return instr_pkg::count_t'(ev);
    endfunction

    a_hwm_monotonic : assert property (
        @(posedge clk) disable iff (!rst_n)
        !counters_clear |=> (rx_hwm >= $past(rx_hwm)) && (tx_hwm >= $past(tx_hwm)) &&
                            (sector_hwm >= $past(sector_hwm)) &&
                            (flux_hwm >= $past(flux_hwm))
    );

endmodule

// File: logic/readback_mux.sv
//================================================
// Register readback
// Registers the word selected by the read offset
//================================================

module readback_mux (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rd_en,
    input  instr_pkg::reg_offset_t  rd_offset,

    input  instr_pkg::byte_count_t  usb_rx_bytes,
    input  instr_pkg::byte_count_t  usb_tx_bytes,
    input  instr_pkg::byte_count_t  dma_bytes,
    input  instr_pkg::count_t       usb_rx_packets,
    input  instr_pkg::count_t       usb_tx_packets,
    input  instr_pkg::count_t       usb_errors,
    input  instr_pkg::count_t       dma_transfers,
    input  instr_pkg::count_t       dma_errors,
    input  instr_pkg::fifo_level_t  rx_hwm,
    input  instr_pkg::fifo_level_t  tx_hwm,
    input  instr_pkg::fifo_level_t  sector_hwm,
    input  instr_pkg::flux_level_t  flux_hwm,
    input  instr_pkg::count_t       fifo_overflows,
    input  instr_pkg::count_t       err_fdd,
    input  instr_pkg::count_t       err_hdd,
    input  instr_pkg::count_t       err_crc,
    input  instr_pkg::count_t       err_timeout,

    output instr_pkg::reg_data_t    reg_rdata
);

    instr_pkg::count_t    err_total;
    instr_pkg::reg_data_t rd_word;

    // Wraps at 32 bits like the individual counters
    assign err_total = err_fdd + err_hdd + err_crc + err_timeout;

    always_comb begin
        case (rd_offset)
            instr_pkg::reg_version:         rd_word = instr_pkg::version_word;
            instr_pkg::reg_control:         rd_word = '0;
            instr_pkg::reg_usb_rx_bytes_lo: rd_word = usb_rx_bytes[31:0];
            instr_pkg::reg_usb_rx_bytes_hi: rd_word = usb_rx_bytes[63:32];
            instr_pkg::reg_usb_tx_bytes_lo: rd_word = usb_tx_bytes[31:0];
            instr_pkg::reg_usb_tx_bytes_hi: rd_word = usb_tx_bytes[63:32];
            instr_pkg::reg_usb_rx_packets:  rd_word = usb_rx_packets;
            instr_pkg::reg_usb_tx_packets:  rd_word = usb_tx_packets;
            instr_pkg::reg_usb_errors:      rd_word = usb_errors;
            instr_pkg::reg_dma_bytes_lo:    rd_word = dma_bytes[31:0];
            instr_pkg::reg_dma_bytes_hi:    rd_word = dma_bytes[63:32];
            instr_pkg::reg_dma_transfers:   rd_word = dma_transfers;
            instr_pkg::reg_dma_errors:      rd_word = dma_errors;
            instr_pkg::reg_fifo_rx_hwm:     rd_word = {22'd0, rx_hwm};
            instr_pkg::reg_fifo_tx_hwm:     rd_word = {22'd0, tx_hwm};
            instr_pkg::reg_fifo_flux_hwm:   rd_word = {19'd0, flux_hwm};
            instr_pkg::reg_fifo_sector_hwm: rd_word = {22'd0, sector_hwm};
            instr_pkg::reg_fifo_overflows:  rd_word = fifo_overflows;
            instr_pkg::reg_err_fdd:         rd_word = err_fdd;
            instr_pkg::reg_err_hdd:         rd_word = err_hdd;
            instr_pkg::reg_err_crc:         rd_word = err_crc;
            instr_pkg::reg_err_timeout:     rd_word = err_timeout;
            instr_pkg::reg_err_total:       rd_word = err_total;
            default:                        rd_word = instr_pkg::bad_offset_word;
        endcase
    end

    // Data holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            reg_rdata <= '0;
        else if (rd_en)
            reg_rdata <= rd_word;
    end

    a_rdata_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en |=> !$isunknown(reg_rdata)
    );

endmodule

// File: logic/instr_regs.sv
//================================================
// Statistics block top level
// Register bus front end, two counter banks and
// the readback mux
//================================================

module instr_regs (
    input  logic                    clk,
    input  logic                    rst_n,

    // Register bus
    input  instr_pkg::reg_data_t    reg_addr,
    input  instr_pkg::reg_data_t    reg_wdata,
    input  logic                    reg_we,
    input  logic                    reg_re,
    output instr_pkg::reg_data_t    reg_rdata,
    output logic                    reg_ready,

    // USB and DMA activity
    input  logic                    usb_rx_valid,
    input  logic                    usb_rx_ready,
    input  logic                    usb_tx_valid,
    input  logic                    usb_tx_ready,
    input  logic                    usb_error,
    input  logic                    dma_done,
    input  logic                    dma_error,
    input  instr_pkg::dma_len_t     dma_length,

    // FIFO monitoring
    input  instr_pkg::fifo_level_t  rx_fifo_level,
    input  instr_pkg::fifo_level_t  tx_fifo_level,
    input  instr_pkg::fifo_level_t  sector_fifo_level,
    input  instr_pkg::flux_level_t  flux_fifo_level,
    input  logic                    rx_fifo_overflow,
    input  logic                    tx_fifo_underrun,
    input  logic                    flux_fifo_overflow,

    // Disk error events
    input  logic                    fdd_error,
    input  logic                    hdd_error,
    input  logic                    crc_error,
    input  logic                    timeout_error
);

    logic                       rd_en;
    instr_pkg::reg_offset_t     rd_offset;
    logic                       counters_clear;

    instr_pkg::byte_count_t     usb_rx_bytes, usb_tx_bytes, dma_bytes;
    instr_pkg::count_t          usb_rx_packets, usb_tx_packets, usb_errors;
    instr_pkg::count_t          dma_transfers, dma_errors;
    instr_pkg::fifo_level_t     rx_hwm, tx_hwm, sector_hwm;
    instr_pkg::flux_level_t     flux_hwm;
    instr_pkg::count_t          fifo_overflows;
    instr_pkg::count_t          err_fdd, err_hdd, err_crc, err_timeout;

    bus_decode i_bus_decode (
        .clk, .rst_n,
        .reg_addr, .reg_wdata, .reg_we, .reg_re,
        .reg_ready, .rd_en, .rd_offset, .counters_clear
    );

    traffic_counters i_traffic_counters (
        .clk, .rst_n, .counters_clear,
        .usb_rx_valid, .usb_rx_ready, .usb_tx_valid, .usb_tx_ready, .usb_error,
        .dma_done, .dma_error, .dma_length,
        .usb_rx_bytes, .usb_tx_bytes, .dma_bytes,
        .usb_rx_packets, .usb_tx_packets, .usb_errors, .dma_transfers, .dma_errors
    );

    fault_counters i_fault_counters (
        .clk, .rst_n, .counters_clear,
        .rx_fifo_level, .tx_fifo_level, .sector_fifo_level, .flux_fifo_level,
        .rx_fifo_overflow, .tx_fifo_underrun, .flux_fifo_overflow,
        .fdd_error, .hdd_error, .crc_error, .timeout_error,
        .rx_hwm, .tx_hwm, .sector_hwm, .flux_hwm,
        .fifo_overflows, .err_fdd, .err_hdd, .err_crc, .err_timeout
    );

    readback_mux i_readback_mux (
        .clk, .rst_n, .rd_en, .rd_offset,
        .usb_rx_bytes, .usb_tx_bytes, .dma_bytes,
        .usb_rx_packets, .usb_tx_packets, .usb_errors, .dma_transfers, .dma_errors,
        .rx_hwm, .tx_hwm, .sector_hwm, .flux_hwm,
        .fifo_overflows, .err_fdd, .err_hdd, .err_crc, .err_timeout,
        .reg_rdata
    );

endmodule

// File: include/tb_checks.svh
//==================================================
// Testbench checks and stimulus source
// Compare tasks for register bus results and a
// Fibonacci LFSR that feeds the event stimulus
//==================================================

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// One LFSR step per bit with the first bit taken landing highest
function automatic logic [15:0] take_bits(input int count);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        bits       = {bits[14:0], lfsr_state[0]};
    end
    return bits;
endfunction

//==================================================
// Compare tasks
//==================================================

task automatic check_data(input string name,
                          input instr_pkg::reg_data_t actual,
                          input instr_pkg::reg_data_t expected);
    if (actual !== expected)
        stop_with_failure($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h",
                                    name, actual, expected));
endtask

task automatic check_ready(input string name, input logic actual, input logic expected);
    if (actual !== expected)
        stop_with_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                                    name, actual, expected));
endtask

`endif

// File: tb/tb_instr_regs.sv
//==================================================
// Statistics block testbench
// Random event injection, register reads against a
// counter model, control clear and watchdog
//==================================================

module tb_instr_regs;

    typedef enum logic [1:0] {op_inj, op_wr, op_rd} op_t;

    typedef struct packed {
        op_t                    op;
        int                     cycles;
        instr_pkg::reg_offset_t offset;
        instr_pkg::reg_data_t   data;
    } step_t;

    localparam int n_steps = 58;

    // Operation, cycles, offset, write data
    localparam step_t steps [n_steps] = '{
        '{op_rd, 4, 12'h000, 0}, '{op_rd, 4, 12'h004, 0}, '{op_rd, 4, 12'h100, 0},
        '{op_rd, 4, 12'hffc, 0}, '{op_inj, 40, 12'h000, 0},
        // Writes that must leave the counters alone
        '{op_wr, 4, 12'h000, 32'h1}, '{op_wr, 4, 12'h004, 32'h2}, '{op_wr, 4, 12'h1d0, 32'h1},
        '{op_rd, 4, 12'h040, 0}, '{op_rd, 4, 12'h044, 0}, '{op_rd, 4, 12'h048, 0},
        '{op_rd, 4, 12'h04c, 0}, '{op_rd, 4, 12'h050, 0}, '{op_rd, 4, 12'h054, 0},
        '{op_rd, 4, 12'h058, 0}, '{op_rd, 4, 12'h080, 0}, '{op_rd, 4, 12'h084, 0},
        '{op_rd, 4, 12'h088, 0}, '{op_rd, 4, 12'h08c, 0}, '{op_rd, 4, 12'h0c0, 0},
        '{op_rd, 4, 12'h0c4, 0}, '{op_rd, 4, 12'h0c8, 0}, '{op_rd, 4, 12'h0cc, 0},
        '{op_rd, 4, 12'h0d0, 0}, '{op_rd, 4, 12'h1c0, 0}, '{op_rd, 4, 12'h1c4, 0},
        '{op_rd, 4, 12'h1c8, 0}, '{op_rd, 4, 12'h1cc, 0}, '{op_rd, 4, 12'h1d0, 0},
        // Clear, then every counter reads zero
        '{op_wr, 4, 12'h004, 32'h1},
        '{op_rd, 4, 12'h040, 0}, '{op_rd, 4, 12'h044, 0}, '{op_rd, 4, 12'h048, 0},
        '{op_rd, 4, 12'h04c, 0}, '{op_rd, 4, 12'h050, 0}, '{op_rd, 4, 12'h054, 0},
        '{op_rd, 4, 12'h058, 0}, '{op_rd, 4, 12'h080, 0}, '{op_rd, 4, 12'h084, 0},
        '{op_rd, 4, 12'h088, 0}, '{op_rd, 4, 12'h08c, 0}, '{op_rd, 4, 12'h0c0, 0},
        '{op_rd, 4, 12'h0c4, 0}, '{op_rd, 4, 12'h0c8, 0}, '{op_rd, 4, 12'h0cc, 0},
        '{op_rd, 4, 12'h0d0, 0}, '{op_rd, 4, 12'h1c0, 0}, '{op_rd, 4, 12'h1c4, 0},
        '{op_rd, 4, 12'h1c8, 0}, '{op_rd, 4, 12'h1cc, 0}, '{op_rd, 4, 12'h1d0, 0},
        '{op_inj, 30, 12'h000, 0},
        '{op_rd, 4, 12'h040, 0}, '{op_rd, 4, 12'h050, 0}, '{op_rd, 4, 12'h080, 0},
        '{op_rd, 4, 12'h0c8, 0}, '{op_rd, 4, 12'h0d0, 0}, '{op_rd, 4, 12'h1d0, 0}
    };

    logic clk = 1'b0;
    logic rst_n;
    instr_pkg::reg_data_t   reg_addr, reg_wdata, reg_rdata;
    logic                   reg_we, reg_re, reg_ready;
    logic                   usb_rx_valid, usb_rx_ready, usb_tx_valid, usb_tx_ready, usb_error;
    logic                   dma_done, dma_error;
    instr_pkg::dma_len_t    dma_length;
    instr_pkg::fifo_level_t rx_fifo_level, tx_fifo_level, sector_fifo_level;
    instr_pkg::flux_level_t flux_fifo_level;
    logic                   rx_fifo_overflow, tx_fifo_underrun, flux_fifo_overflow;
    logic                   fdd_error, hdd_error, crc_error, timeout_error;
    logic [31:0]            lfsr_state = 32'hadb5f28a;

    // Counter model
    instr_pkg::byte_count_t m_usb_rx_bytes, m_usb_tx_bytes, m_dma_bytes;
    instr_pkg::count_t      m_usb_rx_packets, m_usb_tx_packets, m_usb_errors;
    instr_pkg::count_t      m_dma_transfers, m_dma_errors, m_fifo_overflows;
    instr_pkg::fifo_level_t m_rx_hwm, m_tx_hwm, m_sector_hwm;
    instr_pkg::flux_level_t m_flux_hwm;
    instr_pkg::count_t      m_err [4];

    always #10 clk = ~clk;

    instr_regs i_dut (
        .clk, .rst_n, .reg_addr, .reg_wdata, .reg_we, .reg_re, .reg_rdata, .reg_ready,
        .usb_rx_valid, .usb_rx_ready, .usb_tx_valid, .usb_tx_ready, .usb_error,
        .dma_done, .dma_error, .dma_length,
        .rx_fifo_level, .tx_fifo_level, .sector_fifo_level, .flux_fifo_level,
        .rx_fifo_overflow, .tx_fifo_underrun, .flux_fifo_overflow,
        .fdd_error, .hdd_error, .crc_error, .timeout_error
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped on first error");
    endtask

    `include "tb_checks.svh"

    task automatic clear_model();
        m_usb_rx_bytes   = '0;
        m_usb_tx_bytes   = '0;
        m_dma_bytes      = '0;
        m_usb_rx_packets = '0;
        m_usb_tx_packets = '0;
        m_usb_errors     = '0;
        m_dma_transfers  = '0;
        m_dma_errors     = '0;
        m_fifo_overflows = '0;
        m_rx_hwm         = '0;
        m_tx_hwm         = '0;
        m_sector_hwm     = '0;
        m_flux_hwm       = '0;
        for (int k = 0; k < 4; k++)
            m_err[k] = '0;
    endtask

    task automatic drive_idle();
        {usb_rx_valid, usb_rx_ready, usb_tx_valid, usb_tx_ready, usb_error} <= '0;
        {dma_done, dma_error, dma_length} <= '0;
        {rx_fifo_level, tx_fifo_level, sector_fifo_level, flux_fifo_level} <= '0;
        {rx_fifo_overflow, tx_fifo_underrun, flux_fifo_overflow} <= '0;
        {fdd_error, hdd_error, crc_error, timeout_error} <= '0;
    endtask

    // Register word expected at an offset according to the register map
    function automatic instr_pkg::reg_data_t expected_word(input instr_pkg::reg_offset_t off);
        case (off)
            instr_pkg::reg_version:         return instr_pkg::version_word;
            instr_pkg::reg_control:         return '0;
            instr_pkg::reg_usb_rx_bytes_lo: return m_usb_rx_bytes[31:0];
            instr_pkg::reg_usb_rx_bytes_hi: return m_usb_rx_bytes[63:32];
            instr_pkg::reg_usb_tx_bytes_lo: return m_usb_tx_bytes[31:0];
            instr_pkg::reg_usb_tx_bytes_hi: return m_usb_tx_bytes[63:32];
            instr_pkg::reg_usb_rx_packets:  return m_usb_rx_packets;
            instr_pkg::reg_usb_tx_packets:  return m_usb_tx_packets;
            instr_pkg::reg_usb_errors:      return m_usb_errors;
            instr_pkg::reg_dma_bytes_lo:    return m_dma_bytes[31:0];
            instr_pkg::reg_dma_bytes_hi:    return m_dma_bytes[63:32];
            instr_pkg::reg_dma_transfers:   return m_dma_transfers;
            instr_pkg::reg_dma_errors:      return m_dma_errors;
            instr_pkg::reg_fifo_rx_hwm:     return {22'd0, m_rx_hwm};
            instr_pkg::reg_fifo_tx_hwm:     return {22'd0, m_tx_hwm};
            instr_pkg::reg_fifo_flux_hwm:   return {19'd0, m_flux_hwm};
            instr_pkg::reg_fifo_sector_hwm: return {22'd0, m_sector_hwm};
            instr_pkg::reg_fifo_overflows:  return m_fifo_overflows;
            instr_pkg::reg_err_fdd:         return m_err[0];
            instr_pkg::reg_err_hdd:         return m_err[1];
            instr_pkg::reg_err_crc:         return m_err[2];
            instr_pkg::reg_err_timeout:     return m_err[3];
            instr_pkg::reg_err_total:       return m_err[0] + m_err[1] + m_err[2] + m_err[3];
            default:                        return instr_pkg::bad_offset_word;
        endcase
    endfunction

    //==================================================
    // Stimulus
    //==================================================

    task automatic inject_events(input int n);
        logic [6:0]             ev;
        logic [2:0]             flags;
        logic [3:0]             disk;
        instr_pkg::dma_len_t    len;
        instr_pkg::fifo_level_t rx_lvl, tx_lvl, sec_lvl;
        instr_pkg::flux_level_t flux_lvl;
        for (int c = 0; c < n; c++) begin
            ev       = 7'(take_bits(7));
            len      = take_bits(16);
            rx_lvl   = 10'(take_bits(10));
            tx_lvl   = 10'(take_bits(10));
            sec_lvl  = 10'(take_bits(10));
            flux_lvl = 13'(take_bits(13));
            flags    = 3'(take_bits(3));
            disk     = 4'(take_bits(4));
            @(posedge clk);
            {usb_rx_valid, usb_rx_ready, usb_tx_valid, usb_tx_ready} <= ev[3:0];
            {usb_error, dma_done, dma_error} <= ev[6:4];
            dma_length <= len;
            {rx_fifo_level, tx_fifo_level, sector_fifo_level} <= {rx_lvl, tx_lvl, sec_lvl};
            flux_fifo_level <= flux_lvl;
            {rx_fifo_overflow, tx_fifo_underrun, flux_fifo_overflow} <= flags;
            {fdd_error, hdd_error, crc_error, timeout_error} <= disk;
            // Model sees the same values the DUT samples at the next edge
            if (ev[3] && ev[2]) begin
                m_usb_rx_bytes += instr_pkg::usb_word_bytes;
                m_usb_rx_packets++;
            end
            if (ev[1] && ev[0]) begin
                m_usb_tx_bytes += instr_pkg::usb_word_bytes;
                m_usb_tx_packets++;
            end
            if (ev[6])
                m_usb_errors++;
            if (ev[5]) begin
                m_dma_bytes += 64'(len);
                m_dma_transfers++;
            end
            if (ev[4])
                m_dma_errors++;
            if (rx_lvl > m_rx_hwm)
                m_rx_hwm = rx_lvl;
            if (tx_lvl > m_tx_hwm)
                m_tx_hwm = tx_lvl;
            if (sec_lvl > m_sector_hwm)
                m_sector_hwm = sec_lvl;
            if (flux_lvl > m_flux_hwm)
                m_flux_hwm = flux_lvl;
            if (|flags)
                m_fifo_overflows++;
            for (int k = 0; k < 4; k++)
                if (disk[3 - k])
                    m_err[k]++;
        end
        @(posedge clk);
        drive_idle();
    endtask

    // One request with ready expected exactly one cycle later
    task automatic bus_access(input logic is_write, input instr_pkg::reg_offset_t off,
                              input instr_pkg::reg_data_t data);
        @(posedge clk);
        reg_addr  <= {20'd0, off};
        reg_wdata <= data;
        reg_we    <= is_write;
        reg_re    <= !is_write;
        @(posedge clk);
        reg_we <= 1'b0;
        reg_re <= 1'b0;
        @(negedge clk);
        if (reg_ready !== 1'b1)
            stop_with_failure($sformatf("reg_ready missing one cycle after request to 0x%03h",
                                        off));
        if (!is_write)
            check_data($sformatf("reg_rdata[0x%03h]", off), reg_rdata, expected_word(off));
        @(negedge clk);
        check_ready("reg_ready", reg_ready, 1'b0);
    endtask

    //==================================================
    // Main sequence and watchdog
    //==================================================

    initial begin
        rst_n     <= 1'b0;
        reg_addr  <= '0;
        reg_wdata <= '0;
        reg_we    <= 1'b0;
        reg_re    <= 1'b0;
        drive_idle();
        clear_model();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_ready("reg_ready", reg_ready, 1'b0);
        check_data("reg_rdata", reg_rdata, '0);
        for (int i = 0; i < n_steps; i++) begin
            case (steps[i].op)
                op_inj: inject_events(steps[i].cycles);
                op_wr: begin
                    bus_access(1'b1, steps[i].offset, steps[i].data);
                    if (steps[i].offset == instr_pkg::reg_control && steps[i].data[0])
                        clear_model();
                end
                op_rd:   bus_access(1'b0, steps[i].offset, steps[i].data);
                default: stop_with_failure("unknown operation in the stimulus table");
            endcase
        end
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        int total;
        total = 20;
        for (int i = 0; i < n_steps; i++)
            total += steps[i].cycles;
        #(total * 20 * 2);
        stop_with_failure("watchdog expired before the stimulus table finished");
    end

endmodule

// File: vlog.f
+incdir+include
logic/instr_pkg.sv
logic/bus_decode.sv
logic/traffic_counters.sv
logic/fault_counters.sv
logic/readback_mux.sv
logic/instr_regs.sv
tb/tb_instr_regs.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f vlog.f --top-module tb_instr_regs \
        -o tb_instr_regs_sim &&
    ./obj_dir/tb_instr_regs_sim || exit 1
